// ==== flist.f ====
+incdir+include
design/mem_pkg.sv
design/bus_sequencer.sv
design/work_ram.sv
design/palette_ram.sv
design/io_registers.sv
design/sound_fifo.sv
design/bus_read_mux.sv
design/mem_top.sv
tb/mem_top_tb.sv

// ==== Makefile ====
TOP := mem_top_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// ==== include/mem_tb_checks.svh ====
// Stimulus table, compare tasks and bounded write wait included by the memory controller testbench
`ifndef MEM_TB_CHECKS_SVH
`define MEM_TB_CHECKS_SVH

typedef enum logic [2:0] {op_write, op_read, op_gfx, op_pop, op_clear, op_dma, op_inputs} op_e;

// Write rows expect {int_enable, int_acks} in the cycle after the write lands
typedef struct packed {
    op_e       op;
    addr_t     addr;
    word_t     data;      // Pop rows hold the count, DMA rows the address taken during DMA
    mem_size_e size;
    word_t     expected;
} row_t;

localparam int wait_limit = 16;  // Cycles allowed for one write

row_t stimulus [$];

function automatic void add_row(op_e op, addr_t addr, word_t data, mem_size_e size,
                                word_t expected);
    row_t r;
    r = '{op, addr, data, size, expected};
    stimulus.push_back(r);
endfunction

function automatic void load_stimulus();
    add_row(op_read,   32'h0800_0000, 32'h0,         size_word, 32'h0);
    add_row(op_read,   32'h0400_0210, 32'h0,         size_word, 32'h0);  // Just past I/O window
    add_row(op_write,  32'h0300_0010, 32'h1122_3344, size_word, 32'h0);
    add_row(op_read,   32'h0300_0010, 32'h0,         size_word, 32'h1122_3344);
    add_row(op_read,   32'h0800_0010, 32'h0,         size_word, 32'h0);  // Unmapped alias of it
    add_row(op_write,  32'h0300_0011, 32'h5a5a_5a5a, size_byte, 32'h0);  // Lane 1 only
    add_row(op_write,  32'h0300_0012, 32'hbeef_beef, size_half, 32'h0);  // Upper pair
    add_row(op_read,   32'h0300_0010, 32'h0,         size_word, 32'hbeef_5a44);
    add_row(op_write,  32'h0500_0020, 32'h7fff_001f, size_word, 32'h0);
    add_row(op_write,  32'h0500_0220, 32'h03e0_7c00, size_word, 32'h0);  // Object half
    add_row(op_read,   32'h0500_0220, 32'h0,         size_word, 32'h03e0_7c00);
    add_row(op_read,   32'h0500_0020, 32'h0,         size_word, 32'h7fff_001f);
    add_row(op_gfx,    32'h0500_0020, 32'h0,         size_word, 32'h7fff_001f);
    add_row(op_gfx,    32'h0500_0220, 32'h0,         size_word, 32'h03e0_7c00);
    add_row(op_write,  32'h0400_0008, 32'hcafe_f00d, size_word, 32'h0);
    add_row(op_read,   32'h0400_0008, 32'h0,         size_word, 32'hcafe_f00d);
    add_row(op_inputs, 32'h0,         32'h0010_03ff, size_word, 32'h0);  // reg_if, buttons
    add_row(op_read,   32'h0400_0130, 32'h0,         size_word, 32'h0000_03ff);
    add_row(op_inputs, 32'h0,         32'h0010_0155, size_word, 32'h0);
    add_row(op_read,   32'h0400_0130, 32'h0,         size_word, 32'h0000_0155);
    add_row(op_write,  32'h0400_0200, 32'h0000_0023, size_word, 32'h0023_0000);
    add_row(op_write,  32'h0400_0202, 32'h0005_0005, size_half, 32'h0023_0005);
    add_row(op_read,   32'h0400_0200, 32'h0,         size_word, 32'h0010_0023);
    // Ten pushes with one pop after the second, so the last push meets a full FIFO
    for (int i = 0; i < 10; i++) begin
        add_row(op_write, 32'h0400_00a0, 32'hf1f0_0000 + i, size_word, 32'h0023_0000);
        if (i == 1)
            add_row(op_pop, 32'h0, 32'd2, size_word, 32'hf1f0_0000);
    end
    for (int i = 1; i < 4; i++)
        add_row(op_pop, 32'h0, 9 - i, size_word, 32'hf1f0_0000 + i);
    add_row(op_clear,  32'h0,         32'h0,         size_word, 32'h0);
    add_row(op_dma,    32'h0300_0010, 32'h0500_0020, size_word, 32'hbeef_5a44);
endfunction

task automatic check_word(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
        errors++;
        $display("Fail at time %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
endtask

task automatic check_half(string name, half_t expected, half_t actual);
    if (actual !== expected) begin
        errors++;
        $display("Fail at time %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
endtask

task automatic check_count(string name, fifo_count_t expected, fifo_count_t actual);
    if (actual !== expected) begin
        errors++;
        $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
endtask

task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
        errors++;
        $display("Fail at time %0t: %s expected %b, got %b", $time, name, expected, actual);
    end
endtask

// Returns once bus_pause has risen and fallen, counting its high cycles
task automatic wait_write_done(output int high_cycles);
    int   cycles;
    logic seen;
    cycles      = 0;
    seen        = 1'b0;
    high_cycles = 0;
    while (cycles < wait_limit && !(seen && !bus_pause)) begin
        @(posedge clock);
        #1;
        cycles++;
        if (bus_pause) begin
            seen = 1'b1;
            high_cycles++;
        end
    end
    if (!(seen && !bus_pause)) begin
        timeouts++;
        $display("Timeout: bus_pause did not rise and fall within %0d cycles", wait_limit);
    end
endtask

`endif

// ==== tb/mem_top_tb.sv ====
// Testbench for mem_top that applies the stimulus table and random work RAM round trips
`timescale 1ns/1ps

module mem_top_tb;
    import mem_pkg::*;

    logic        clock;
    logic        reset;
    addr_t       bus_addr;
    word_t       bus_wdata;
    mem_size_e   bus_size;
    logic        bus_write;
    logic        dma_active;
    addr_t       gfx_palette_bg_addr;
    addr_t       gfx_palette_obj_addr;
    half_t       buttons;
    half_t       reg_if;
    logic        fifo_read;
    logic        fifo_clear;
    word_t       bus_rdata;
    logic        bus_pause;
    word_t       gfx_palette_bg_data;
    word_t       gfx_palette_obj_data;
    half_t       int_enable;
    half_t       int_acks;
    word_t       fifo_value;
    fifo_count_t fifo_size;
    int          errors;
    int          timeouts;
    int          seed;

    `include "mem_tb_checks.svh"

    mem_top dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Sample and drive point 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic write_bus(addr_t addr, word_t data, mem_size_e size, word_t expected);
        int high_cycles;
        bus_addr  = addr;
        bus_wdata = data;
        bus_size  = size;
        bus_write = 1'b1;
        wait_write_done(high_cycles);
        bus_write = 1'b0;  // Released before the next write could start
        if (high_cycles != 1) begin
            errors++;
            $display("Fail at time %0t: bus_pause high cycles expected 1, got %0d",
                     $time, high_cycles);
        end
        check_half("int_enable", expected[31:16], int_enable);
        check_half("int_acks", expected[15:0], int_acks);
        next_cycle();
        check_half("int_acks", 16'h0000, int_acks);  // Acknowledge is a single-cycle pulse
    endtask

    task automatic apply_row(row_t r);
        case (r.op)
            op_write: write_bus(r.addr, r.data, r.size, r.expected);
            op_read: begin
                bus_addr = r.addr;
                next_cycle();
                check_word("bus_rdata", r.expected, bus_rdata);
            end
            op_gfx: begin
                gfx_palette_bg_addr  = {23'h0, r.addr[8:0]};
                gfx_palette_obj_addr = {23'h0, r.addr[8:0]};
                next_cycle();
                if (r.addr[9])
                    check_word("gfx_palette_obj_data", r.expected, gfx_palette_obj_data);
                else
                    check_word("gfx_palette_bg_data", r.expected, gfx_palette_bg_data);
            end
            op_pop: begin
                check_count("fifo_size", r.data[3:0], fifo_size);
                check_word("fifo_value", r.expected, fifo_value);
                fifo_read = 1'b1;
                next_cycle();
                fifo_read = 1'b0;
            end
            op_clear: begin
                fifo_clear = 1'b1;
                next_cycle();
                fifo_clear = 1'b0;
                check_count("fifo_size", r.expected[3:0], fifo_size);
            end
            op_inputs: begin
                buttons = r.data[15:0];
                reg_if  = r.data[31:16];
            end
            op_dma: begin
                bus_addr = r.addr;
                next_cycle();
                check_word("bus_rdata", r.expected, bus_rdata);
                dma_active = 1'b1;
                bus_addr   = r.data;  // DMA moves the bus elsewhere
                next_cycle();
                next_cycle();
                dma_active = 1'b0;
                #4;
                check_word("bus_rdata", r.expected, bus_rdata);  // Mid-cycle after the fall
                next_cycle();
            end
            default: ;
        endcase
    endtask

    initial begin
        word_t rand_word;
        addr_t rand_addr;
        errors               = 0;
        timeouts             = 0;
        seed                 = 22;
        reset                = 1'b1;
        bus_addr             = '0;
        bus_wdata            = '0;
        bus_size             = size_word;
        bus_write            = 1'b0;
        dma_active           = 1'b0;
        fifo_read            = 1'b0;
        fifo_clear           = 1'b0;
        gfx_palette_bg_addr  = '0;
        gfx_palette_obj_addr = '0;
        buttons              = '0;
        reg_if               = '0;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        check_bit("bus_pause", 1'b0, bus_pause);
        check_half("int_acks", 16'h0000, int_acks);
        check_half("int_enable", 16'h0000, int_enable);
        check_count("fifo_size", 4'd0, fifo_size);
        load_stimulus();
        foreach (stimulus[i]) begin
            if (timeouts == 0)
                apply_row(stimulus[i]);
        end
        // Random word round trips through work RAM
        for (int i = 0; i < 4 && timeouts == 0; i++) begin
            rand_addr = 32'h0300_0000 | (32'($random(seed)) & 32'h0000_7ffc);
            rand_word = $random(seed);
            write_bus(rand_addr, rand_word, size_word, 32'h0023_0000);
            bus_addr = rand_addr;
            next_cycle();
            check_word("bus_rdata", rand_word, bus_rdata);
        end
        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== design/mem_top.sv ====
// Memory controller top level joining the bus sequencer, memories, I/O registers, FIFO and read mux
`timescale 1ns/1ps

module mem_top (
    input  logic                 clock,
    input  logic                 reset,
    input  mem_pkg::addr_t       bus_addr,
    input  mem_pkg::word_t       bus_wdata,
    input  mem_pkg::mem_size_e   bus_size,
    input  logic                 bus_write,
    input  logic                 dma_active,
    input  mem_pkg::addr_t       gfx_palette_bg_addr,
    input  mem_pkg::addr_t       gfx_palette_obj_addr,
    input  mem_pkg::half_t       buttons,
    input  mem_pkg::half_t       reg_if,
    input  logic                 fifo_read,
    input  logic                 fifo_clear,
    output mem_pkg::word_t       bus_rdata,
    output logic                 bus_pause,
    output mem_pkg::word_t       gfx_palette_bg_data,
    output mem_pkg::word_t       gfx_palette_obj_data,
    output mem_pkg::half_t       int_enable,
    output mem_pkg::half_t       int_acks,
    output mem_pkg::word_t       fifo_value,
    output mem_pkg::fifo_count_t fifo_size
);
    import mem_pkg::*;

    addr_t    mem_addr;     // Live or held address for the RAMs
    addr_t    reg_addr;
    region_e  read_region;
    byte_en_t work_we;
    byte_en_t palette_we;
    byte_en_t io_we;
    word_t    work_rdata;
    word_t    palette_rdata;
    word_t    io_rdata;
    logic     fifo_push;

    bus_sequencer sequencer_i (
        .clock, .reset,
        .bus_addr, .bus_size, .bus_write,
        .bus_pause, .mem_addr, .reg_addr, .read_region,
        .work_we, .palette_we, .io_we
    );

    work_ram work_ram_i (
        .clock, .reset,
        .mem_addr, .bus_wdata, .work_we,
        .read_data (work_rdata)
    );

    palette_ram palette_ram_i (
        .clock, .reset,
        .mem_addr, .bus_wdata, .palette_we,
        .gfx_palette_bg_addr, .gfx_palette_obj_addr,
        .read_data (palette_rdata),
        .gfx_palette_bg_data, .gfx_palette_obj_data
    );

    io_registers io_registers_i (
        .clock, .reset,
        .reg_addr, .bus_wdata, .io_we,
        .buttons, .reg_if, .fifo_value,
        .read_data (io_rdata),
        .int_enable, .int_acks, .fifo_push
    );

    // Sound FIFO A, filled through the I/O window
    sound_fifo sound_fifo_i (
        .clock, .reset,
        .fifo_push, .bus_wdata, .fifo_read, .fifo_clear,
        .fifo_value, .fifo_size
    );

    bus_read_mux read_mux_i (
        .clock, .reset,
        .read_region,
        .work_data    (work_rdata),
        .palette_data (palette_rdata),
        .io_data      (io_rdata),
        .dma_active,
        .bus_rdata
    );

endmodule

// ==== design/bus_read_mux.sv ====
// Bus read data select by latched region, with CPU read data replay after a DMA preemption
`timescale 1ns/1ps

module bus_read_mux (
    input  logic             clock,
    input  logic             reset,
    input  mem_pkg::region_e read_region,
    input  mem_pkg::word_t   work_data,
    input  mem_pkg::word_t   palette_data,
    input  mem_pkg::word_t   io_data,
    input  logic             dma_active,
    output mem_pkg::word_t   bus_rdata
);
    import mem_pkg::*;

    word_t selected;
    word_t cpu_rdata_q;  // CPU read data when DMA took over
    logic  dma_active_q;
    logic  dma_rise;
    logic  dma_fall;

    always_comb begin
        case (read_region)
            region_work:    selected = work_data;
            region_palette: selected = palette_data;
            region_io:      selected = io_data;
            default:        selected = '0;  // Unmapped
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            dma_active_q <= 1'b0;
        else
            dma_active_q <= dma_active;
    end

    assign dma_rise = dma_active && !dma_active_q;
    assign dma_fall = dma_active_q && !dma_active;

    always_ff @(posedge clock) begin
        if (dma_rise)
            cpu_rdata_q <= bus_rdata;
    end

    // CPU sees its old word again in the first cycle it regains the bus
    assign bus_rdata = dma_fall ? cpu_rdata_q : selected;

endmodule

// ==== design/sound_fifo.sv ====
// Eight-entry sound FIFO A with occupancy count, ignoring push when full and pop when empty
`timescale 1ns/1ps

module sound_fifo (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 fifo_push,
    input  mem_pkg::word_t       bus_wdata,
    input  logic                 fifo_read,
    input  logic                 fifo_clear,
    output mem_pkg::word_t       fifo_value,
    output mem_pkg::fifo_count_t fifo_size
);
    import mem_pkg::*;

    localparam int ptr_bits = $clog2(fifo_depth);

    word_t               entries [fifo_depth];
    logic [ptr_bits-1:0] put_ptr;
    logic [ptr_bits-1:0] get_ptr;
    logic                full;
    logic                empty;
    logic                push_ok;
    logic                pop_ok;

    assign full    = (fifo_size == fifo_count_t'(fifo_depth));
    assign empty   = (fifo_size == '0);
    assign push_ok = fifo_push && !full;
    assign pop_ok  = fifo_read && !empty;

    assign fifo_value = entries[get_ptr];  // Head is visible without a pop

    always_ff @(posedge clock) begin
        if (push_ok)
            entries[put_ptr] <= bus_wdata;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            put_ptr   <= '0;
            get_ptr   <= '0;
            fifo_size <= '0;
        end else if (fifo_clear) begin
            put_ptr   <= '0;
            get_ptr   <= '0;
            fifo_size <= '0;
        end else begin
            if (push_ok)
                put_ptr <= put_ptr + 1'b1;  // Wraps with the ring
            if (pop_ok)
                get_ptr <= get_ptr + 1'b1;
            if (push_ok && !pop_ok)
                fifo_size <= fifo_size + 1'b1;
            else if (pop_ok && !push_ok)
                fifo_size <= fifo_size - 1'b1;
        end
    end

    count_in_range: assert property (
        @(posedge clock) disable iff (reset) fifo_size <= fifo_count_t'(fifo_depth)
    ) else $error("FIFO count above depth");

endmodule

// ==== design/io_registers.sv ====
// Memory-mapped I/O register window with key input, interrupt word and sound FIFO write port
`timescale 1ns/1ps

module io_registers (
    input  logic              clock,
    input  logic              reset,
    input  mem_pkg::addr_t    reg_addr,
    input  mem_pkg::word_t    bus_wdata,
    input  mem_pkg::byte_en_t io_we,
    input  mem_pkg::half_t    buttons,
    input  mem_pkg::half_t    reg_if,
    input  mem_pkg::word_t    fifo_value,
    output mem_pkg::word_t    read_data,
    output mem_pkg::half_t    int_enable,
    output mem_pkg::half_t    int_acks,
    output logic              fifo_push
);
    import mem_pkg::*;

    localparam int index_bits = $clog2(io_reg_count);

    word_t                 regs [io_reg_count];
    addr_t                 offset;
    logic [index_bits-1:0] index;
    logic                  in_window;
    word_t                 stored;
    logic [1:0]            ack_we;

    assign offset    = reg_addr - io_base;
    assign index     = offset[index_bits+1:2];
    assign in_window = offset < addr_t'(io_reg_count * 4);
    assign stored    = in_window ? regs[index] : '0;

    // Plain byte-writable storage for the whole window
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < io_reg_count; i++)
                regs[i] <= '0;
        end else if (in_window) begin
            regs[index] <= write_merge(regs[index], bus_wdata, io_we);
        end
    end

    assign int_enable = regs[int_index][15:0];

    assign ack_we = (in_window && index == index_bits'(int_index)) ? io_we[3:2] : 2'b00;

    // Acknowledge pulses for one cycle, a write wins over the self clear
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            int_acks <= '0;
        end else begin
            int_acks[7:0]  <= ack_we[0] ? bus_wdata[23:16] : 8'h00;
            int_acks[15:8] <= ack_we[1] ? bus_wdata[31:24] : 8'h00;
        end
    end

    assign fifo_push = in_window && index == index_bits'(fifo_a_index) && io_we[0];

    always_comb begin
        if (!in_window)
            read_data = '0;
        else if (index == index_bits'(keyinput_index))
            read_data = {stored[31:16], buttons};  // Low half is live buttons
        else if (index == index_bits'(int_index))
            read_data = {reg_if, int_enable};
        else if (index == index_bits'(fifo_a_index))
            read_data = fifo_value;
        else
            read_data = stored;
    end

endmodule

// ==== design/palette_ram.sv ====
// Background and object palette banks with a shared bus port and one graphics read port per bank
`timescale 1ns/1ps

module palette_ram (
    input  logic              clock,
    input  logic              reset,
    input  mem_pkg::addr_t    mem_addr,
    input  mem_pkg::word_t    bus_wdata,
    input  mem_pkg::byte_en_t palette_we,
    input  mem_pkg::addr_t    gfx_palette_bg_addr,
    input  mem_pkg::addr_t    gfx_palette_obj_addr,
    output mem_pkg::word_t    read_data,
    output mem_pkg::word_t    gfx_palette_bg_data,
    output mem_pkg::word_t    gfx_palette_obj_data
);
    import mem_pkg::*;

    localparam int index_bits = $clog2(palette_bank_words);

    logic [index_bits-1:0] index;
    logic                  obj_sel_q;  // Bank of the last bus access
    addr_t                 gfx_addr [2];
    word_t                 gfx_data [2];
    word_t                 bus_data [2];

    assign index       = mem_addr[index_bits+1:2];
    assign gfx_addr[0] = gfx_palette_bg_addr;
    assign gfx_addr[1] = gfx_palette_obj_addr;

    // Bank 0 background, bank 1 object
    for (genvar b = 0; b < 2; b++) begin : bank_g
        word_t    mem [palette_bank_words];
        byte_en_t bank_we;

        assign bank_we = (mem_addr[9] == 1'(b)) ? palette_we : '0;

        always_ff @(posedge clock) begin
            for (int i = 0; i < 4; i++) begin
                if (bank_we[i])
                    mem[index][8*i +: 8] <= bus_wdata[8*i +: 8];
            end
            bus_data[b] <= write_merge(mem[index], bus_wdata, bank_we);
            gfx_data[b] <= mem[gfx_addr[b][index_bits+1:2]];  // Byte address within bank
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            obj_sel_q <= 1'b0;
        else
            obj_sel_q <= mem_addr[9];
    end

    assign read_data            = obj_sel_q ? bus_data[1] : bus_data[0];
    assign gfx_palette_bg_data  = gfx_data[0];
    assign gfx_palette_obj_data = gfx_data[1];

endmodule

// ==== design/work_ram.sv ====
// Internal work RAM on the bus port with byte writes and write-first registered read
`timescale 1ns/1ps

module work_ram (
    input  logic              clock,
    input  logic              reset,
    input  mem_pkg::addr_t    mem_addr,
    input  mem_pkg::word_t    bus_wdata,
    input  mem_pkg::byte_en_t work_we,
    output mem_pkg::word_t    read_data
);
    import mem_pkg::*;

    localparam int index_bits = $clog2(work_ram_words);

    word_t                 mem [work_ram_words];
    logic [index_bits-1:0] index;

    assign index = mem_addr[index_bits+1:2];  // Word aligned

    always_ff @(posedge clock) begin
        for (int i = 0; i < 4; i++) begin
            if (work_we[i])
                mem[index][8*i +: 8] <= bus_wdata[8*i +: 8];
        end
    end

    // Written lanes show the new data in the same read
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            read_data <= '0;
        else
            read_data <= write_merge(mem[index], bus_wdata, work_we);
    end

endmodule

// ==== design/bus_sequencer.sv ====
// Write-pause FSM, address and size latch, region decode and byte-enable decode for the bus
`timescale 1ns/1ps

module bus_sequencer (
    input  logic               clock,
    input  logic               reset,
    input  mem_pkg::addr_t     bus_addr,
    input  mem_pkg::mem_size_e bus_size,
    input  logic               bus_write,
    output logic               bus_pause,
    output mem_pkg::addr_t     mem_addr,
    output mem_pkg::addr_t     reg_addr,
    output mem_pkg::region_e   read_region,
    output mem_pkg::byte_en_t  work_we,
    output mem_pkg::byte_en_t  palette_we,
    output mem_pkg::byte_en_t  io_we
);
    import mem_pkg::*;

    seq_state_e state;
    mem_size_e  size_q;
    addr_t      io_offset;
    byte_en_t   lane_en;
    logic       writing;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= seq_idle;
            reg_addr <= '0;
            size_q   <= size_byte;
        end else begin
            reg_addr <= bus_addr;  // Latched every cycle
            size_q   <= bus_size;
            case (state)
                seq_idle:  state <= bus_write ? seq_write : seq_idle;
                default:   state <= seq_idle;  // Single pause cycle
            endcase
        end
    end

    assign writing   = (state == seq_write);
    assign bus_pause = writing;
    assign mem_addr  = writing ? reg_addr : bus_addr;  // Master holds address while paused

    assign io_offset = reg_addr - io_base;

    always_comb begin
        if (reg_addr[31:24] == work_region)
            read_region = region_work;
        else if (reg_addr[31:24] == palette_region)
            read_region = region_palette;
        else if (io_offset < addr_t'(io_reg_count * 4))
            read_region = region_io;
        else
            read_region = region_none;
    end

    // Little endian lanes from the low address bits
    always_comb begin
        case (size_q)
            size_byte: lane_en = byte_en_t'(4'b0001 << reg_addr[1:0]);
            size_half: lane_en = reg_addr[1] ? 4'b1100 : 4'b0011;
            size_word: lane_en = 4'b1111;
            default:   lane_en = 4'b0000;
        endcase
    end

    assign work_we    = (writing && read_region == region_work)    ? lane_en : '0;
    assign palette_we = (writing && read_region == region_palette) ? lane_en : '0;
    assign io_we      = (writing && read_region == region_io)      ? lane_en : '0;

    // A held write must let the master through every other cycle
    pause_single_cycle: assert property (
        @(posedge clock) disable iff (reset) bus_pause |=> !bus_pause
    ) else $error("bus_pause high for two cycles");

endmodule

// ==== design/mem_pkg.sv ====
// Shared widths, address map, enums and memory depths, imported by every memory controller module
package mem_pkg;

    typedef logic [31:0] word_t;        // Bus, graphics and FIFO data word
    typedef logic [31:0] addr_t;        // Byte address
    typedef logic [15:0] half_t;        // Register half
    typedef logic [3:0]  byte_en_t;     // One enable per byte lane
    typedef logic [3:0]  fifo_count_t;  // Occupancy 0 to 8

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    // Target of the access latched last cycle
    typedef enum logic [1:0] {
        region_none,
        region_work,
        region_palette,
        region_io
    } region_e;

    typedef enum logic {
        seq_idle,
        seq_write
    } seq_state_e;

    // Address map
    localparam logic [7:0] work_region    = 8'h03;
    localparam logic [7:0] palette_region = 8'h05;
    localparam addr_t      io_base        = 32'h0400_0000;
    localparam int         io_reg_count   = 132;

    // Word indices inside the I/O window
    localparam int keyinput_index = 76;
    localparam int int_index      = 128;
    localparam int fifo_a_index   = 40;

    localparam int work_ram_words     = 8192;
    localparam int palette_bank_words = 128;
    localparam int fifo_depth         = 8;

    // Replaces the enabled byte lanes of a stored word
    function automatic word_t write_merge(word_t old_word, word_t new_word, byte_en_t be);
        word_t result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i])
                result[8*i +: 8] = new_word[8*i +: 8];
        end
        return result;
    endfunction

endpackage
